// File: verilog/rv_pkg.sv
// ########################################
// rv64i slice shared types
// ########################################

package rv_pkg;

  localparam int xlen = 64;

  // major opcodes, bits [6:0]
  typedef enum logic [6:0] {
    opc_load      = 7'h03,
    opc_misc_mem  = 7'h0f,
    opc_op_imm    = 7'h13,
    opc_auipc     = 7'h17,
    opc_op_imm_32 = 7'h1b,
    opc_store     = 7'h23,
    opc_op        = 7'h33,
    opc_lui       = 7'h37,
    opc_op_32     = 7'h3b,
    opc_branch    = 7'h63,
    opc_jalr      = 7'h67,
    opc_jal       = 7'h6f,
    opc_system    = 7'h73
  } opc_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_slt, alu_sltu, alu_xor,
    alu_or, alu_and, alu_sll, alu_srl, alu_sra
  } alu_op_e;

  typedef enum logic [3:0] {
    bj_none, bj_beq, bj_bne, bj_blt, bj_bge,
    bj_bltu, bj_bgeu, bj_jal, bj_jalr
  } bj_op_e;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic [31:0]     inst;
  } fetch_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    alu_op_e         alu_op;
    bj_op_e          bj_op;
    logic            is_word;
    logic            rd_w_ena;
    logic [4:0]      rd_addr;
    logic            pc_to_reg;
    logic            unsupported;
    logic [xlen-1:0] exe_op1;
    logic [xlen-1:0] exe_op2;
    logic [xlen-1:0] jmp_imm;
  } dec_t;

  typedef struct packed {
    logic [xlen-1:0] pc;
    logic            rd_w_ena;
    logic [4:0]      rd_addr;
    logic [xlen-1:0] wdata;
    logic [xlen-1:0] next_pc;
    logic            unsupported;
  } retire_t;

endpackage

// File: verilog/id_stage.sv
// ########################################
// rv64i decode stage
// ########################################

module id_stage (
  input  rv_pkg::fetch_t inst_in,
  output logic [4:0]     rs1_r_addr,
  output logic [4:0]     rs2_r_addr,
  input  logic [63:0]    r_data1,
  input  logic [63:0]    r_data2,
  output rv_pkg::dec_t   dec
);
  import rv_pkg::*;

  logic [31:0]     inst;
  logic [6:0]      opcode;
  logic [4:0]      rd;
  logic [2:0]      funct3;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_s;
  logic [xlen-1:0] imm_b;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            reg_form;
  logic            sra_sel;
  logic            executed;
  logic            rs1_ena;
  logic            rs2_ena;
  logic            rd_ena;
  alu_op_e         alu_op;
  bj_op_e          bj_op;
  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [xlen-1:0] jmp;

  assign inst   = inst_in.inst;
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // immediates of every format, sign extended to xlen
  assign imm_i = {{52{inst[31]}}, inst[31:20]};
  assign imm_s = {{52{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_b = {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
  assign imm_u = {{32{inst[31]}}, inst[31:12], 12'b0};
  assign imm_j = {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

  assign reg_form = (opcode == opc_op) || (opcode == opc_op_32);
  assign sra_sel  = reg_form ? (funct7 == 7'h20) : (funct7[6:1] == 6'h10);

  assign executed = opcode inside {opc_op_imm, opc_op_imm_32, opc_op, opc_op_32,
                                   opc_lui, opc_auipc, opc_branch, opc_jal, opc_jalr};
  assign rs1_ena  = opcode inside {opc_load, opc_misc_mem, opc_op_imm, opc_op_imm_32,
                                   opc_store, opc_op, opc_op_32, opc_branch, opc_jalr,
                                   opc_system};
  assign rs2_ena  = opcode inside {opc_op, opc_op_32, opc_store, opc_branch};
  assign rd_ena   = executed && (opcode != opc_branch);

  // unread operands select x0
  assign rs1_r_addr = rs1_ena ? rs1 : 5'd0;
  assign rs2_r_addr = rs2_ena ? rs2 : 5'd0;

  always_comb begin
    alu_op = alu_add;
    bj_op  = bj_none;
    case (opcode)
      opc_op, opc_op_32, opc_op_imm, opc_op_imm_32: begin
        case (funct3)
          3'h0: alu_op = (reg_form && funct7 == 7'h20) ? alu_sub : alu_add;
          3'h1: alu_op = alu_sll;
          3'h2: alu_op = alu_slt;
          3'h3: alu_op = alu_sltu;
          3'h4: alu_op = alu_xor;
          3'h5: alu_op = sra_sel ? alu_sra : alu_srl;
          3'h6: alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      opc_branch: begin
        // xor for equality, slt/sltu for ordering
        case (funct3)
          3'h0: begin
            alu_op = alu_xor;
            bj_op  = bj_beq;
          end
          3'h1: begin
            alu_op = alu_xor;
            bj_op  = bj_bne;
          end
          3'h4: begin
            alu_op = alu_slt;
            bj_op  = bj_blt;
          end
          3'h5: begin
            alu_op = alu_slt;
            bj_op  = bj_bge;
          end
          3'h6: begin
            alu_op = alu_sltu;
            bj_op  = bj_bltu;
          end
          3'h7: begin
            alu_op = alu_sltu;
            bj_op  = bj_bgeu;
          end
          default: alu_op = alu_sub;
        endcase
      end
      opc_jal:  bj_op = bj_jal;
      opc_jalr: bj_op = bj_jalr;
      default:  alu_op = alu_add;
    endcase
  end

  always_comb begin
    case (opcode)
      opc_op_imm, opc_op, opc_branch, opc_load, opc_store, opc_misc_mem, opc_system:
        op1 = r_data1;
      opc_op_imm_32, opc_op_32: op1 = {32'b0, r_data1[31:0]};
      opc_auipc: op1 = inst_in.pc;
      // lui adds its immediate to zero
      default: op1 = '0;
    endcase
  end

  always_comb begin
    case (opcode)
      opc_op_imm, opc_op_imm_32, opc_load, opc_misc_mem: op2 = imm_i;
      opc_store: op2 = imm_s;
      opc_auipc, opc_lui: op2 = imm_u;
      opc_op, opc_branch: op2 = r_data2;
      opc_op_32: op2 = {32'b0, r_data2[31:0]};
      default: op2 = '0;
    endcase
  end

  // jalr offset relative to pc so execute adds pc uniformly
  always_comb begin
    case (opcode)
      opc_branch: jmp = imm_b;
      opc_jal:    jmp = imm_j;
      opc_jalr:   jmp = r_data1 + imm_i - inst_in.pc;
      default:    jmp = '0;
    endcase
  end

  assign dec.pc          = inst_in.pc;
  assign dec.alu_op      = alu_op;
  assign dec.bj_op       = bj_op;
  assign dec.is_word     = (opcode == opc_op_32) || (opcode == opc_op_imm_32);
  assign dec.rd_w_ena    = rd_ena;
  assign dec.rd_addr     = rd_ena ? rd : 5'd0;
  assign dec.pc_to_reg   = (opcode == opc_jal) || (opcode == opc_jalr);
  assign dec.unsupported = !executed;
  assign dec.exe_op1     = op1;
  assign dec.exe_op2     = op2;
  assign dec.jmp_imm     = jmp;

endmodule

// File: verilog/regfile.sv
// ########################################
// integer register file
// ########################################

module regfile (
  input  logic        clk,
  input  logic        reset,
  input  logic [4:0]  rs1_r_addr,
  input  logic [4:0]  rs2_r_addr,
  output logic [63:0] r_data1,
  output logic [63:0] r_data2,
  input  logic        w_ena,
  input  logic [4:0]  w_addr,
  input  logic [63:0] w_data
);

  logic [63:0] regs [1:31];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (w_ena && w_addr != 5'd0) begin
      regs[w_addr] <= w_data;
    end
  end

  // x0 reads zero and a pending write is forwarded
  always_comb begin
    r_data1 = '0;
    if (rs1_r_addr != 5'd0) begin
      r_data1 = (w_ena && w_addr == rs1_r_addr) ? w_data : regs[rs1_r_addr];
    end
  end

  always_comb begin
    r_data2 = '0;
    if (rs2_r_addr != 5'd0) begin
      r_data2 = (w_ena && w_addr == rs2_r_addr) ? w_data : regs[rs2_r_addr];
    end
  end

endmodule

// File: verilog/exe_stage.sv
// ########################################
// execute stage
// ########################################

module exe_stage (
  input  rv_pkg::dec_t    dec,
  output rv_pkg::retire_t result
);
  import rv_pkg::*;

  logic [xlen-1:0] op1;
  logic [xlen-1:0] op2;
  logic [5:0]      shamt;
  logic [xlen-1:0] sra_src;
  logic [xlen-1:0] raw;
  logic [xlen-1:0] alu_res;
  logic [xlen-1:0] link;
  logic            taken;

  assign op1 = dec.exe_op1;
  assign op2 = dec.exe_op2;

  // word shifts use five bits of shift amount
  assign shamt   = dec.is_word ? {1'b0, op2[4:0]} : op2[5:0];
  assign sra_src = dec.is_word ? {{32{op1[31]}}, op1[31:0]} : op1;

  always_comb begin
    case (dec.alu_op)
      alu_add:  raw = op1 + op2;
      alu_sub:  raw = op1 - op2;
      alu_slt:  raw = {63'b0, $signed(op1) < $signed(op2)};
      alu_sltu: raw = {63'b0, op1 < op2};
      alu_xor:  raw = op1 ^ op2;
      alu_or:   raw = op1 | op2;
      alu_and:  raw = op1 & op2;
      alu_sll:  raw = op1 << shamt;
      alu_srl:  raw = op1 >> shamt;
      alu_sra:  raw = $signed(sra_src) >>> shamt;
      default:  raw = '0;
    endcase
  end

  assign alu_res = dec.is_word ? {{32{raw[31]}}, raw[31:0]} : raw;

  always_comb begin
    case (dec.bj_op)
      bj_beq:           taken = (alu_res == '0);
      bj_bne:           taken = (alu_res != '0);
      bj_blt, bj_bltu:  taken = alu_res[0];
      bj_bge, bj_bgeu:  taken = !alu_res[0];
      bj_jal, bj_jalr:  taken = 1'b1;
      default:          taken = 1'b0;
    endcase
  end

  assign link = dec.pc + 64'd4;

  assign result.pc          = dec.pc;
  assign result.rd_w_ena    = dec.rd_w_ena;
  assign result.rd_addr     = dec.rd_addr;
  assign result.wdata       = dec.pc_to_reg ? link : alu_res;
  assign result.next_pc     = taken ? dec.pc + dec.jmp_imm : link;
  assign result.unsupported = dec.unsupported;

endmodule

// File: verilog/retire_stage.sv
// ########################################
// retire register and write-back
// ########################################

module retire_stage (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  rv_pkg::retire_t rec_in,
  output logic            out_valid,
  input  logic            out_ready,
  output rv_pkg::retire_t out_data,
  output logic            w_ena,
  output logic [4:0]      w_addr,
  output logic [63:0]     w_data
);
  import rv_pkg::*;

  logic    held_valid;
  retire_t held;
  logic    out_fire;

  // free slot, or the held record leaves this cycle
  assign in_ready = !held_valid || out_ready;
  assign out_fire = held_valid && out_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      held_valid <= 1'b0;
    end else if (in_ready) begin
      held_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) begin
      held <= rec_in;
    end
  end

  assign out_valid = held_valid;
  assign out_data  = held;

  // commit on acceptance; x0 never written
  assign w_ena  = out_fire && held.rd_w_ena && (held.rd_addr != 5'd0);
  assign w_addr = held.rd_addr;
  assign w_data = held.wdata;

endmodule

// File: verilog/rv_core.sv
// ########################################
// rv64i execution slice top
// ########################################

module rv_core (
  input  logic            clk,
  input  logic            reset,
  input  logic            in_valid,
  output logic            in_ready,
  input  rv_pkg::fetch_t  in_data,
  output logic            out_valid,
  input  logic            out_ready,
  output rv_pkg::retire_t out_data
);
  import rv_pkg::*;

  logic [4:0]  rs1_r_addr;
  logic [4:0]  rs2_r_addr;
  logic [63:0] r_data1;
  logic [63:0] r_data2;
  logic        w_ena;
  logic [4:0]  w_addr;
  logic [63:0] w_data;
  dec_t        dec;
  retire_t     exe_result;

  id_stage id_stage_i (
    .inst_in    (in_data),
    .rs1_r_addr (rs1_r_addr),
    .rs2_r_addr (rs2_r_addr),
    .r_data1    (r_data1),
    .r_data2    (r_data2),
    .dec        (dec)
  );

  regfile regfile_i (
    .clk        (clk),
    .reset      (reset),
    .rs1_r_addr (rs1_r_addr),
    .rs2_r_addr (rs2_r_addr),
    .r_data1    (r_data1),
    .r_data2    (r_data2),
    .w_ena      (w_ena),
    .w_addr     (w_addr),
    .w_data     (w_data)
  );

  exe_stage exe_stage_i (
    .dec    (dec),
    .result (exe_result)
  );

  retire_stage retire_stage_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .rec_in    (exe_result),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data),
    .w_ena     (w_ena),
    .w_addr    (w_addr),
    .w_data    (w_data)
  );

endmodule

// File: bench/rv_core_sva.sv
// ########################################
// rv_core handshake assertions
// ########################################

module rv_core_sva (
  input logic            clk,
  input logic            reset,
  input logic            in_valid,
  input logic            in_ready,
  input logic            out_valid,
  input logic            out_ready,
  input rv_pkg::retire_t out_data
);
  timeunit 1ns;
  timeprecision 1ps;

  int fail_count = 0;

  // sync reset clears the slot one edge later
  assert property (@(posedge clk) reset |=> !out_valid)
    else begin
      $error("out_valid high while in reset");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
                   out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      $error("retire record changed under back-pressure");
      fail_count++;
    end

  assert property (@(posedge clk) disable iff (reset)
                   in_ready == (!out_valid || out_ready))
    else begin
      $error("in_ready does not follow the slot state");
      fail_count++;
    end

  // an accepted instruction is held on the next cycle
  assert property (@(posedge clk) disable iff (reset)
                   in_valid && in_ready |=> out_valid)
    else begin
      $error("accepted instruction did not retire one cycle later");
      fail_count++;
    end

endmodule

bind rv_core rv_core_sva rv_core_sva_i (.*);

// File: bench/tb_rv_core.sv
// ########################################
// rv64i slice directed testbench
// ########################################

module tb_rv_core;
  timeunit 1ns;
  timeprecision 1ps;
  import rv_pkg::*;

  localparam int reset_cycles = 10;
  localparam int stall_cycles = 6;
  // upper bound on instructions issued
  localparam int instr_budget = 300;

  localparam logic [6:0] op_load  = 7'h03;
  localparam logic [6:0] op_imm   = 7'h13;
  localparam logic [6:0] op_auipc = 7'h17;
  localparam logic [6:0] op_imm32 = 7'h1b;
  localparam logic [6:0] op_store = 7'h23;
  localparam logic [6:0] op_reg   = 7'h33;
  localparam logic [6:0] op_lui   = 7'h37;
  localparam logic [6:0] op_reg32 = 7'h3b;
  localparam logic [6:0] op_jalr  = 7'h67;

  logic    clk = 1'b0;
  logic    reset;
  logic    in_valid;
  logic    in_ready;
  fetch_t  in_data;
  logic    out_valid;
  logic    out_ready;
  retire_t out_data;

  logic [63:0] mregs [32];
  retire_t     exp_q [$];
  logic [63:0] pc;
  logic        acc_prev = 1'b0;
  string       test_name;
  int          errors = 0;
  int          checks = 0;

  rv_core dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_data   (in_data),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_data  (out_data)
  );

  always #50 clk = ~clk;

  task automatic compare(input string what, input logic [63:0] want, input logic [63:0] got);
    checks++;
    if (want !== got) begin
      errors++;
      $display("FAIL %s %s: expected %h, actual %h", test_name, what, want, got);
    end
  endtask

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
  endfunction

  function automatic logic [63:0] alu64_ref(input logic [2:0] f3, input logic alt,
                                            input logic [63:0] a, input logic [63:0] b);
    logic signed [63:0] sa;
    sa = a;
    case (f3)
      3'h0: return alt ? a - b : a + b;
      3'h1: return a << b[5:0];
      3'h2: return {63'b0, $signed(a) < $signed(b)};
      3'h3: return {63'b0, a < b};
      3'h4: return a ^ b;
      3'h5: begin
        if (alt) begin
          return sa >>> b[5:0];
        end
        return a >> b[5:0];
      end
      3'h6: return a | b;
      default: return a & b;
    endcase
  endfunction

  // 32-bit op with sign-extended result
  function automatic logic [63:0] word_ref(input logic [2:0] f3, input logic alt,
                                           input logic [63:0] a, input logic [63:0] b);
    logic [31:0]        r;
    logic signed [31:0] sa;
    sa = a[31:0];
    r = '0;
    case (f3)
      3'h0: r = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
      3'h1: r = a[31:0] << b[4:0];
      3'h5: begin
        if (alt) begin
          r = sa >>> b[4:0];
        end else begin
          r = a[31:0] >> b[4:0];
        end
      end
      default: r = '0;
    endcase
    return {{32{r[31]}}, r};
  endfunction

  // architectural model that commits in program order
  task automatic execute_model(input logic [63:0] ipc, input logic [31:0] inst,
                               output retire_t r);
    logic [6:0]  opc;
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [63:0] a;
    logic [63:0] b;
    logic [63:0] imm;
    logic [63:0] upper;
    logic [63:0] res;
    logic        alt;
    logic        wr;
    logic        take;
    opc   = inst[6:0];
    f3    = inst[14:12];
    rd    = inst[11:7];
    a     = mregs[inst[19:15]];
    b     = mregs[inst[24:20]];
    imm   = {{52{inst[31]}}, inst[31:20]};
    upper = {{32{inst[31]}}, inst[31:12], 12'h000};
    alt   = inst[30] && (opc == op_reg || opc == op_reg32 || f3 == 3'h5);
    res   = '0;
    wr    = 1'b1;
    take  = 1'b0;
    r     = '0;
    r.pc      = ipc;
    r.next_pc = ipc + 64'd4;
    case (opc)
      op_imm:   res = alu64_ref(f3, alt, a, imm);
      op_reg:   res = alu64_ref(f3, alt, a, b);
      op_imm32: res = word_ref(f3, alt, a, imm);
      op_reg32: res = word_ref(f3, alt, a, b);
      op_lui:   res = upper;
      op_auipc: res = ipc + upper;
      7'h63: begin
        wr = 1'b0;
        case (f3)
          3'h0: take = (a == b);
          3'h1: take = (a != b);
          3'h4: take = ($signed(a) < $signed(b));
          3'h5: take = ($signed(a) >= $signed(b));
          3'h6: take = (a < b);
          default: take = (a >= b);
        endcase
        if (take) begin
          r.next_pc = ipc + {{51{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
        end
      end
      7'h6f: begin
        res = ipc + 64'd4;
        r.next_pc = ipc + {{43{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      end
      op_jalr: begin
        res = ipc + 64'd4;
        r.next_pc = (a + imm) & ~64'd1;
      end
      default: begin
        wr = 1'b0;
        r.unsupported = 1'b1;
      end
    endcase
    r.rd_w_ena = wr;
    r.rd_addr  = wr ? rd : 5'd0;
    r.wdata    = res;
    if (wr && rd != 5'd0) begin
      mregs[rd] = res;
    end
  endtask

  // runs from one falling edge to the next
  task automatic clock_step(output logic accepted);
    retire_t want;
    retire_t rec;
    #10;
    if (acc_prev) begin
      compare("retire latency", 1'b1, out_valid);
    end
    if (out_valid && out_ready) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("Retire record at pc %h with no instruction outstanding", out_data.pc);
      end else begin
        want = exp_q.pop_front();
        compare("pc", want.pc, out_data.pc);
        compare("next_pc", want.next_pc, out_data.next_pc);
        compare("rd_w_ena", want.rd_w_ena, out_data.rd_w_ena);
        compare("rd_addr", want.rd_addr, out_data.rd_addr);
        compare("unsupported", want.unsupported, out_data.unsupported);
        if (want.rd_w_ena) begin
          compare("wdata", want.wdata, out_data.wdata);
        end
      end
    end
    accepted = in_valid && in_ready;
    if (accepted) begin
      execute_model(in_data.pc, in_data.inst, rec);
      exp_q.push_back(rec);
    end
    acc_prev = accepted;
    @(negedge clk);
  endtask

  task automatic present(input logic [31:0] inst);
    in_valid     = 1'b1;
    in_data.pc   = pc;
    in_data.inst = inst;
  endtask

  task automatic await_accept();
    logic acc;
    acc = 1'b0;
    while (!acc) begin
      clock_step(acc);
    end
    in_valid = 1'b0;
    pc = pc + 64'd4;
  endtask

  task automatic issue(input logic [31:0] inst);
    present(inst);
    await_accept();
  endtask

  task automatic drain_outputs();
    logic acc;
    while (exp_q.size() != 0) begin
      clock_step(acc);
    end
  endtask

  // lui + addiw gives any sign-extended 32-bit value
  task automatic lui_addiw(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    issue(u_type(hi[19:0], rd, op_lui));
    issue(i_type(v[11:0], rd, 3'h0, rd, op_imm32));
  endtask

  // x31 is scratch
  task automatic build_dword(input logic [4:0] rd, input logic [63:0] v);
    lui_addiw(rd, v[63:32]);
    issue(i_type(12'd32, rd, 3'h1, rd, op_imm));
    lui_addiw(5'd31, v[31:0]);
    issue(i_type(12'd32, 5'd31, 3'h1, 5'd31, op_imm));
    issue(i_type(12'd32, 5'd31, 3'h5, 5'd31, op_imm));
    issue(r_type(7'h00, 5'd31, rd, 3'h6, rd, op_reg));
  endtask

  task automatic reset_state();
    test_name = "reset";
    #10;
    compare("out_valid", 1'b0, out_valid);
    compare("in_ready", 1'b1, in_ready);
    @(negedge clk);
    issue(i_type(12'h123, 5'd0, 3'h0, 5'd1, op_imm));
    drain_outputs();
  endtask

  task automatic alu_ops();
    test_name = "alu";
    for (int n = 0; n < 2; n++) begin
      build_dword(5'd1, {$urandom, $urandom});
      build_dword(5'd2, {$urandom, $urandom});
      for (int f = 0; f < 8; f++) begin
        issue(r_type(7'h00, 5'd2, 5'd1, 3'(f), 5'(3 + f), op_reg));
      end
      issue(r_type(7'h20, 5'd2, 5'd1, 3'h0, 5'd11, op_reg));
      issue(r_type(7'h20, 5'd2, 5'd1, 3'h5, 5'd12, op_reg));
      for (int f = 0; f < 8; f++) begin
        if (f != 1 && f != 5) begin
          issue(i_type(12'($urandom), 5'd1, 3'(f), 5'(13 + f), op_imm));
        end
      end
      issue(i_type({6'h00, 6'($urandom)}, 5'd1, 3'h1, 5'd21, op_imm));
      issue(i_type({6'h00, 6'($urandom)}, 5'd1, 3'h5, 5'd22, op_imm));
      issue(i_type({6'h10, 6'($urandom)}, 5'd1, 3'h5, 5'd23, op_imm));
      issue(u_type(20'($urandom), 5'd24, op_lui));
      issue(u_type(20'($urandom), 5'd25, op_auipc));
    end
    drain_outputs();
  endtask

  task automatic word_ops();
    test_name = "word";
    build_dword(5'd1, {32'($urandom), 32'h7fff_fff0});
    build_dword(5'd2, {32'($urandom), 32'h0000_0104});
    build_dword(5'd3, {32'($urandom), 32'h8000_0001});
    issue(r_type(7'h00, 5'd2, 5'd1, 3'h0, 5'd4, op_reg32));
    issue(r_type(7'h20, 5'd2, 5'd3, 3'h0, 5'd5, op_reg32));
    issue(r_type(7'h00, 5'd2, 5'd1, 3'h1, 5'd6, op_reg32));
    issue(r_type(7'h00, 5'd2, 5'd3, 3'h5, 5'd7, op_reg32));
    issue(r_type(7'h20, 5'd2, 5'd3, 3'h5, 5'd8, op_reg32));
    issue(i_type(12'h7ff, 5'd1, 3'h0, 5'd9, op_imm32));
    issue(i_type({7'h20, 5'd31}, 5'd3, 3'h5, 5'd10, op_imm32));
    drain_outputs();
  endtask

  task automatic branches_jumps();
    logic [2:0]  br_f3 [6];
    logic [63:0] va;
    br_f3 = '{3'h0, 3'h1, 3'h4, 3'h5, 3'h6, 3'h7};
    test_name = "branch";
    // x3 is negative signed but larger unsigned
    va = {1'b0, 31'($urandom), $urandom};
    build_dword(5'd1, va);
    build_dword(5'd2, va);
    build_dword(5'd3, {1'b1, 31'($urandom), $urandom});
    for (int i = 0; i < 6; i++) begin
      issue(b_type(13'($urandom) & 13'h1ffe, 5'd2, 5'd1, br_f3[i]));
      issue(b_type(13'($urandom) & 13'h1ffe, 5'd3, 5'd1, br_f3[i]));
      issue(b_type(13'($urandom) & 13'h1ffe, 5'd1, 5'd3, br_f3[i]));
    end
    test_name = "jump";
    issue(j_type(21'($urandom) & 21'h1ffffe, 5'd5));
    build_dword(5'd7, {$urandom, $urandom} & ~64'd1);
    issue(i_type(12'($urandom) & 12'hffe, 5'd7, 3'h0, 5'd6, op_jalr));
    issue(i_type(12'($urandom) & 12'hffe, 5'd7, 3'h0, 5'd7, op_jalr));
    drain_outputs();
  endtask

  task automatic forward_and_stall();
    retire_t snap;
    test_name = "forwarding";
    issue(i_type(12'h155, 5'd0, 3'h0, 5'd1, op_imm));
    issue(r_type(7'h00, 5'd1, 5'd1, 3'h0, 5'd2, op_reg));
    issue(r_type(7'h20, 5'd1, 5'd2, 3'h0, 5'd3, op_reg));
    issue(i_type(12'h7ff, 5'd0, 3'h0, 5'd0, op_imm));
    issue(r_type(7'h00, 5'd0, 5'd0, 3'h0, 5'd4, op_reg));
    issue(r_type(7'h00, 5'd0, 5'd3, 3'h0, 5'd5, op_reg));
    drain_outputs();
    test_name = "backpressure";
    out_ready = 1'b0;
    issue(i_type(12'h003, 5'd5, 3'h0, 5'd6, op_imm));
    snap = out_data;
    // consumer waits behind its held producer
    present(r_type(7'h00, 5'd6, 5'd6, 3'h0, 5'd7, op_reg));
    for (int i = 0; i < stall_cycles; i++) begin
      #10;
      compare("held out_valid", 1'b1, out_valid);
      compare("held in_ready", 1'b0, in_ready);
      compare("held record", 1'b1, out_data === snap);
      @(negedge clk);
    end
    out_ready = 1'b1;
    await_accept();
    drain_outputs();
  endtask

  task automatic unsupported_ops();
    test_name = "unsupported";
    issue(i_type(12'h02a, 5'd0, 3'h0, 5'd9, op_imm));
    issue(i_type(12'h000, 5'd1, 3'h3, 5'd9, op_load));
    issue(r_type(7'h00, 5'd9, 5'd1, 3'h3, 5'd8, op_store));
    issue(32'h0000_0073);
    issue(r_type(7'h00, 5'd0, 5'd9, 3'h0, 5'd10, op_reg));
    issue(r_type(7'h00, 5'd0, 5'd8, 3'h0, 5'd11, op_reg));
    drain_outputs();
  endtask

  initial begin
    #((instr_budget * (stall_cycles + 4) + reset_cycles) * 100);
    $display("Timeout: the DUT did not finish the instruction stream in time");
    $display("Some tests failed");
    $finish;
  end

  initial begin
    void'($urandom(55));
    reset     = 1'b1;
    in_valid  = 1'b0;
    in_data   = '0;
    out_ready = 1'b1;
    pc        = 64'h0000_0000_8000_0000;
    for (int i = 0; i < 32; i++) begin
      mregs[i] = '0;
    end
    repeat (reset_cycles) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    reset_state();
    alu_ops();
    word_ops();
    branches_jumps();
    forward_and_stall();
    unsupported_ops();
    $display("Checks run: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, dut_i.rv_core_sva_i.fail_count);
    if (errors == 0 && dut_i.rv_core_sva_i.fail_count == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

// File: filelist.f
verilog/rv_pkg.sv
verilog/id_stage.sv
verilog/regfile.sv
verilog/exe_stage.sv
verilog/retire_stage.sv
verilog/rv_core.sv
bench/rv_core_sva.sv
bench/tb_rv_core.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/id_stage.sv
  - verilog/regfile.sv
  - verilog/exe_stage.sv
  - verilog/retire_stage.sv
  - verilog/rv_core.sv
  - target: test
    files:
      - bench/rv_core_sva.sv
      - bench/tb_rv_core.sv
